// File: hdl/pccore_consts.svh
//////////////////////////////////////////////////
// Sizes and timing of the peripheral controller core
// Include in any RTL or testbench file that needs them
//////////////////////////////////////////////////
`ifndef PCCORE_CONSTS_SVH
`define PCCORE_CONSTS_SVH

//////////////////////////////////////////////////
// Address map
`define PC_NUM_SLOTS    9                        // Peripheral slots on the bus
`define PC_SLOT_BITS    4                        // Upper paddr field
`define PC_REG_BITS     8                        // Lower paddr field
`define PC_ADDR_BITS    12                       // APB address width
`define PC_DATA_BITS    8                        // Bus and APB data width

//////////////////////////////////////////////////
// Register file of one slot
`define PC_NUM_REGS     8                        // Implemented registers per slot
`define PC_NUM_ID_REGS  2                        // ID low and high byte
`define PC_NUM_SCRATCH  (`PC_NUM_REGS - `PC_NUM_ID_REGS) // Read/write bytes
`define PC_ID_BITS      16                       // Peripheral ID width

//////////////////////////////////////////////////
// Timing
`define PC_SLOT_WAIT    2                        // Stall cycles before ack
`define PC_TIMEOUT_PER_XFER (`PC_SLOT_WAIT + 6)  // Cycle budget per transfer
`define PC_TIMEOUT_BASE 100                      // Fixed slack on top of the budget

`endif

// File: hdl/pc_bus_pkg.sv
//////////////////////////////////////////////////
// Internal peripheral bus types, shared by bridge,
// slots and response collector
//////////////////////////////////////////////////
`include "pccore_consts.svh"

package pc_bus_pkg;

    //////////////////////////////////////////////////
    // Opcode
    typedef enum logic {
        BUS_READ  = 1'b0,                        // Register onto the chain
        BUS_WRITE = 1'b1                         // wdata into register
    } bus_op_e;

    //////////////////////////////////////////////////
    // Request, broadcast to every slot
    typedef struct packed {
        logic                       valid;       // Held until done
        bus_op_e                    op;          // Read or write
        logic [`PC_SLOT_BITS-1:0]   slot;        // Target slot
        logic [`PC_REG_BITS-1:0]    reg_idx;     // Register inside the slot
        logic [`PC_DATA_BITS-1:0]   wdata;       // Write data
    } bus_req_t;                                 // 22 bits

    // Response of one slot
    typedef struct packed {
        logic stall;                             // Slot claims, needs more cycles
        logic ack;                               // Transfer happens this cycle
    } slot_resp_t;

endpackage

// File: hdl/pc_map_pkg.sv
//////////////////////////////////////////////////
// Address map, register classes and peripheral ID
// table of the slots
//////////////////////////////////////////////////
`include "pccore_consts.svh"

package pc_map_pkg;

    typedef logic [`PC_SLOT_BITS-1:0] slot_idx_t;   // Slot number
    typedef logic [`PC_REG_BITS-1:0]  reg_idx_t;    // Register number
    typedef logic [`PC_ID_BITS-1:0]   periph_id_t;  // Peripheral ID

    // APB address split, slot in the upper bits
    typedef struct packed {
        slot_idx_t slot;
        reg_idx_t  reg_idx;
    } addr_map_t;

    typedef enum logic [1:0] {
        REG_ID_LO   = 2'd0,                      // ID bits 7:0, read only
        REG_ID_HI   = 2'd1,                      // ID bits 15:8, read only
        REG_SCRATCH = 2'd2,                      // Read/write byte
        REG_NONE    = 2'd3                       // Not implemented
    } reg_sel_e;

    //////////////////////////////////////////////////
    // Peripheral ID of each slot
    function automatic periph_id_t slot_id(slot_idx_t idx);
        case (idx)
            4'h0:    return 16'h002f;
            4'h1:    return 16'h0024;
            4'h2:    return 16'h001b;
            4'h3:    return 16'h001a;
            4'h4:    return 16'h001d;
            4'h5:    return 16'h0029;
            4'h6:    return 16'h0008;
            4'h7:    return 16'h001e;
            4'h8:    return 16'h0026;
            default: return 16'h0000;            // Empty slot
        endcase
    endfunction

    // Class of a register index
    function automatic reg_sel_e reg_class(reg_idx_t idx);
        if (idx == 0) return REG_ID_LO;
        if (idx == 1) return REG_ID_HI;
        if (idx < `PC_NUM_REGS) return REG_SCRATCH;
        return REG_NONE;
    endfunction

endpackage

// File: hdl/apb_bus_bridge.sv
//////////////////////////////////////////////////
// APB3 slave that turns each transfer into one
// request on the internal peripheral bus
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pccore_consts.svh"

module apb_bus_bridge (
    input  logic                      clk,
    input  logic                      arst_n,
    // APB slave side
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`PC_ADDR_BITS-1:0]  paddr,
    input  logic [`PC_DATA_BITS-1:0]  pwdata,
    output logic [`PC_DATA_BITS-1:0]  prdata,
    output logic                      pready,
    output logic                      pslverr,
    // Internal bus side
    output pc_bus_pkg::bus_req_t      req,
    output logic [`PC_DATA_BITS-1:0]  chain_head,
    input  logic                      done,
    input  logic                      err,
    input  logic [`PC_DATA_BITS-1:0]  rdata
);

    typedef enum logic [1:0] {
        IDLE,                                    // Waiting for a setup phase
        ACCESS,                                  // Request out, waiting for done
        RESPOND                                  // Single pready cycle
    } state_e;

    state_e                     state;
    logic                       valid_q;         // Request valid
    pc_bus_pkg::bus_op_e        op_q;            // Captured direction
    pc_map_pkg::addr_map_t      addr_q;          // Captured slot and register
    logic [`PC_DATA_BITS-1:0]   wdata_q;         // Captured write data
    logic                       setup;           // APB setup phase seen

    assign setup = psel && !penable;

    //////////////////////////////////////////////////
    // Control FSM
    // Request rises with the first access cycle and pready follows done by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            valid_q <= 1'b0;
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            pready  <= 1'b0;                     // Pulses only
            pslverr <= 1'b0;
            case (state)
                IDLE: begin
                    if (setup) begin
                        valid_q <= 1'b1;         // Visible in first access cycle
                        state   <= ACCESS;
                    end
                end
                ACCESS: begin
                    if (done) begin
                        valid_q <= 1'b0;         // Low for at least one cycle
                        pready  <= 1'b1;
                        pslverr <= err;
                        state   <= RESPOND;
                    end
                end
                RESPOND: state <= IDLE;          // Master closes the transfer here
                default: state <= IDLE;
            endcase
        end
    end

    // Address, opcode and data latched in the setup phase
    always_ff @(posedge clk) begin
        if (state == IDLE && setup) begin
            op_q    <= pwrite ? pc_bus_pkg::BUS_WRITE : pc_bus_pkg::BUS_READ;
            addr_q  <= pc_map_pkg::addr_map_t'(paddr); // Slot in the upper bits
            wdata_q <= pwdata;
        end
    end

    // Read data for the pready cycle is zero on writes and errors
    always_ff @(posedge clk) begin
        if (state == ACCESS && done) begin
            if (op_q == pc_bus_pkg::BUS_READ && !err)
                prdata <= rdata;
            else
                prdata <= '0;
        end
    end

    //////////////////////////////////////////////////
    // Request to the slots
    always_comb begin
        req.valid   = valid_q;
        req.op      = op_q;
        req.slot    = addr_q.slot;
        req.reg_idx = addr_q.reg_idx;
        req.wdata   = wdata_q;
    end

    assign chain_head = wdata_q;                 // Head of the read chain carries the write data

endmodule

// File: hdl/periph_slot.sv
//////////////////////////////////////////////////
// One peripheral slot, ID and scratch registers
// with wait states, instanced once per slot
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pccore_consts.svh"

module periph_slot #(
    parameter int SLOT_INDEX = 0                 // Position on the bus
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  pc_bus_pkg::bus_req_t      req,
    input  logic [`PC_DATA_BITS-1:0]  chain_in,  // From the next slot up
    output logic [`PC_DATA_BITS-1:0]  chain_out, // Toward slot 0
    output pc_bus_pkg::slot_resp_t    resp
);

    localparam pc_map_pkg::slot_idx_t  MY_SLOT  = pc_map_pkg::slot_idx_t'(SLOT_INDEX);
    localparam pc_map_pkg::periph_id_t MY_ID    = pc_map_pkg::slot_id(MY_SLOT);
    localparam int                     CNT_BITS = $clog2(`PC_SLOT_WAIT + 2);
    localparam int                     SCR_BITS = $clog2(`PC_NUM_SCRATCH);

    logic [`PC_DATA_BITS-1:0] scratch [`PC_NUM_SCRATCH]; // Read/write bytes
    logic [CNT_BITS-1:0]      cnt;               // Wait states so far
    logic                     served;            // Acked, wait for valid to drop
    pc_map_pkg::reg_sel_e     cls;               // Class of addressed register
    logic [SCR_BITS-1:0]      scr_idx;           // Scratch byte index
    logic                     hit;               // We own this transfer
    logic [`PC_DATA_BITS-1:0] rd_val;            // Addressed register value

    //////////////////////////////////////////////////
    // Decode
    assign cls     = pc_map_pkg::reg_class(req.reg_idx);
    assign scr_idx = SCR_BITS'(req.reg_idx - `PC_NUM_ID_REGS);
    // Unimplemented registers are not claimed, so the collector flags them
    assign hit     = req.valid && (req.slot == MY_SLOT) &&
                     (cls != pc_map_pkg::REG_NONE) && !served;

    // Stall for the wait states, then ack once
    assign resp.stall = hit && (cnt != CNT_BITS'(`PC_SLOT_WAIT));
    assign resp.ack   = hit && (cnt == CNT_BITS'(`PC_SLOT_WAIT));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt    <= '0;
            served <= 1'b0;
            for (int i = 0; i < `PC_NUM_SCRATCH; i++)
                scratch[i] <= '0;
        end else begin
            if (!req.valid) begin                // Transfer over, rearm
                cnt    <= '0;
                served <= 1'b0;
            end else if (hit) begin
                if (resp.ack)
                    served <= 1'b1;
                else
                    cnt <= cnt + 1'b1;
            end
            // ID writes are acked and dropped
            if (resp.ack && req.op == pc_bus_pkg::BUS_WRITE &&
                cls == pc_map_pkg::REG_SCRATCH)
                scratch[scr_idx] <= req.wdata;
        end
    end

    //////////////////////////////////////////////////
    // Read mux and chain
    always_comb begin
        case (cls)
            pc_map_pkg::REG_ID_LO:   rd_val = MY_ID[7:0];
            pc_map_pkg::REG_ID_HI:   rd_val = MY_ID[15:8];
            pc_map_pkg::REG_SCRATCH: rd_val = scratch[scr_idx];
            default:                 rd_val = '0;
        endcase
    end

    // Our byte replaces the chain only on the read ack cycle
    assign chain_out = (resp.ack && req.op == pc_bus_pkg::BUS_READ) ? rd_val : chain_in;

endmodule

// File: hdl/bus_return.sv
//////////////////////////////////////////////////
// Collects slot responses and the chain tail into
// one done pulse with error flag and read data
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pccore_consts.svh"

module bus_return (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         req_valid,
    input  pc_bus_pkg::slot_resp_t [`PC_NUM_SLOTS-1:0]   resp,
    input  logic [`PC_DATA_BITS-1:0]                     chain_tail,
    output logic                                         done,
    output logic                                         err,
    output logic [`PC_DATA_BITS-1:0]                     rdata
);

    logic any_stall;                             // Some slot still busy
    logic any_ack;                               // Some slot acks now
    logic answered;                              // Done already given for this request

    //////////////////////////////////////////////////
    // OR of all slots
    always_comb begin
        any_stall = 1'b0;
        any_ack   = 1'b0;
        for (int i = 0; i < `PC_NUM_SLOTS; i++) begin
            any_stall |= resp[i].stall;
            any_ack   |= resp[i].ack;
        end
    end

    // Nobody stalls or acks in the first cycle means nobody claims the address
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done     <= 1'b0;
            err      <= 1'b0;
            answered <= 1'b0;
        end else begin
            done <= 1'b0;                        // One cycle only
            if (!req_valid) begin
                answered <= 1'b0;
            end else if (!answered) begin
                if (any_ack) begin
                    done     <= 1'b1;
                    err      <= 1'b0;
                    answered <= 1'b1;
                end else if (!any_stall) begin
                    done     <= 1'b1;            // Unclaimed
                    err      <= 1'b1;
                    answered <= 1'b1;
                end
            end
        end
    end

    // Chain tail is only meaningful on the ack cycle
    always_ff @(posedge clk) begin
        if (req_valid && !answered && any_ack)
            rdata <= chain_tail;
    end

endmodule

// File: hdl/pccore_top.sv
//////////////////////////////////////////////////
// Peripheral controller core, APB slave in front
// of the slot bus with its read chain
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pccore_consts.svh"

module pccore_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`PC_ADDR_BITS-1:0]  paddr,
    input  logic [`PC_DATA_BITS-1:0]  pwdata,
    output logic [`PC_DATA_BITS-1:0]  prdata,
    output logic                      pready,
    output logic                      pslverr
);

    pc_bus_pkg::bus_req_t                       req;        // Broadcast request
    pc_bus_pkg::slot_resp_t [`PC_NUM_SLOTS-1:0] resp;       // One per slot
    logic [`PC_DATA_BITS-1:0] chain [`PC_NUM_SLOTS+1];      // Top entry is the head
    logic                     done;              // Transfer finished
    logic                     err;               // No slot claimed it
    logic [`PC_DATA_BITS-1:0] rdata;             // Byte off the chain

    //////////////////////////////////////////////////
    // APB side
    apb_bus_bridge bridge_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .req        (req),
        .chain_head (chain[`PC_NUM_SLOTS]),
        .done       (done),
        .err        (err),
        .rdata      (rdata)
    );

    //////////////////////////////////////////////////
    // Slots, chain runs from the highest slot down to 0
    for (genvar k = 0; k < `PC_NUM_SLOTS; k++) begin : g_slot
        periph_slot #(
            .SLOT_INDEX (k)
        ) slot_i (
            .clk        (clk),
            .arst_n     (arst_n),
            .req        (req),
            .chain_in   (chain[k+1]),
            .chain_out  (chain[k]),
            .resp       (resp[k])
        );
    end

    // Response collector at the chain tail
    bus_return return_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req.valid),
        .resp       (resp),
        .chain_tail (chain[0]),
        .done       (done),
        .err        (err),
        .rdata      (rdata)
    );

endmodule

// File: sim/pccore_checker.sv
//////////////////////////////////////////////////
// APB and slot bus timing assertions, bound into
// the core top level by the testbench
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pccore_consts.svh"

module pccore_checker (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pready,
    input  pc_bus_pkg::bus_req_t                       req,
    input  pc_bus_pkg::slot_resp_t [`PC_NUM_SLOTS-1:0] resp
);

    localparam logic [3:0] MAX_WAIT = 4'(`PC_SLOT_WAIT + 3); // Setup edge to pready edge

    logic                     waiting;           // Transfer open, pready not yet seen
    logic [3:0]               wait_cnt;          // Edges since the setup phase
    logic [`PC_NUM_SLOTS-1:0] acks;              // Ack bit of each slot

    always_comb begin
        for (int i = 0; i < `PC_NUM_SLOTS; i++)
            acks[i] = resp[i].ack;
    end

    //////////////////////////////////////////////////
    // Latency counter from the setup phase
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            waiting  <= 1'b0;
            wait_cnt <= '0;
        end else if (psel && !penable && !waiting) begin
            waiting  <= 1'b1;                    // Setup phase sampled
            wait_cnt <= 4'd1;
        end else if (waiting && pready) begin
            waiting  <= 1'b0;                    // Master closes here
        end else if (waiting) begin
            wait_cnt <= wait_cnt + 4'd1;
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    a_pready_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        pready |=> !pready)
        else $error("pready held longer than one cycle");

    a_pready_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (waiting && !pready) |-> (wait_cnt < MAX_WAIT))
        else $error("pready too late after access start");

    a_one_ack: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(acks))
        else $error("more than one slot acks at once");

    // Request frozen until the bridge drops valid
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        req.valid |=> (!req.valid || $stable(req)))
        else $error("bus request changed while valid");

endmodule

// File: sim/pccore_tb.sv
//////////////////////////////////////////////////
// Testbench of the core with random APB traffic
// checked against a register model of all slots
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pccore_consts.svh"

module pccore_tb;

    localparam int N_SWEEP   = `PC_NUM_SLOTS * `PC_NUM_SCRATCH; // Reads of every scratch byte
    localparam int N_ID      = `PC_NUM_SLOTS * 6;  // ID reads, writes, reads again
    localparam int N_RAND_W  = 100;
    localparam int N_RAND_R  = 100;
    localparam int N_BAD     = 40;
    localparam int N_MIX     = 200;
    localparam int NUM_XFERS = 3 * N_SWEEP + N_ID + N_RAND_W + N_RAND_R + N_BAD + N_MIX;
    localparam int TIMEOUT_CYCLES = NUM_XFERS * `PC_TIMEOUT_PER_XFER + `PC_TIMEOUT_BASE;

    // Peripheral IDs per slot
    localparam logic [15:0] ID_TABLE [`PC_NUM_SLOTS] = '{
        16'h002f, 16'h0024, 16'h001b, 16'h001a, 16'h001d,
        16'h0029, 16'h0008, 16'h001e, 16'h0026
    };

    logic                     clk;
    logic                     arst_n;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`PC_ADDR_BITS-1:0] paddr;
    logic [`PC_DATA_BITS-1:0] pwdata;
    logic [`PC_DATA_BITS-1:0] prdata;
    logic                     pready;
    logic                     pslverr;

    logic [7:0] scratch_mdl [`PC_NUM_SLOTS][`PC_NUM_SCRATCH]; // Expected scratch bytes
    int         cycles;                          // Edges since time 0

    pccore_top pccore_top_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    bind pccore_top pccore_checker checker_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pready  (pready),
        .req     (req),
        .resp    (resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                   // 8 ns period
    end

    // Run length guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("** FAIL **");
            $fatal(1, "Timeout, run still busy after %0d cycles", TIMEOUT_CYCLES);
        end
    end

    //////////////////////////////////////////////////
    // Model
    function automatic logic [11:0] make_addr(int slot, int ridx);
        return {4'(slot), 8'(ridx)};
    endfunction

    // No slot claims it
    function automatic logic addr_err(logic [11:0] addr);
        return (int'(addr[11:8]) >= `PC_NUM_SLOTS) || (int'(addr[7:0]) >= `PC_NUM_REGS);
    endfunction

    function automatic logic [7:0] model_rdata(logic [11:0] addr);
        int slot;
        int ridx;
        slot = int'(addr[11:8]);
        ridx = int'(addr[7:0]);
        if (ridx == 0) return ID_TABLE[slot][7:0];
        if (ridx == 1) return ID_TABLE[slot][15:8];
        return scratch_mdl[slot][ridx - `PC_NUM_ID_REGS];
    endfunction

    function automatic logic [11:0] random_scratch_addr();
        return make_addr(int'($urandom % `PC_NUM_SLOTS),
                         `PC_NUM_ID_REGS + int'($urandom % `PC_NUM_SCRATCH));
    endfunction

    // Empty slot or register past the implemented ones
    function automatic logic [11:0] unmapped_addr();
        if ($urandom % 2 == 0)
            return make_addr(`PC_NUM_SLOTS + int'($urandom % (16 - `PC_NUM_SLOTS)),
                             int'($urandom % 256));
        return make_addr(int'($urandom % `PC_NUM_SLOTS),
                         `PC_NUM_REGS + int'($urandom % (256 - `PC_NUM_REGS)));
    endfunction

    function automatic logic [11:0] any_addr();
        int pick;
        pick = int'($urandom % 10);
        if (pick < 7) return random_scratch_addr();
        if (pick < 8) return make_addr(int'($urandom % `PC_NUM_SLOTS), int'($urandom % 2));
        return unmapped_addr();
    endfunction

    //////////////////////////////////////////////////
    // Checks and bus tasks
    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Called 1 ns after a rising edge and returns at the same phase
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [7:0] data,
                            output logic [7:0] rd, output logic err);
        psel    = 1'b1;                          // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1'b1;                       // Access phase
        @(negedge clk);
        while (!pready) @(negedge clk);          // Sample mid cycle
        rd  = prdata;
        err = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic access(input logic wr, input logic [11:0] addr, input logic [7:0] data);
        logic [7:0] rd;
        logic       err;
        logic       exp_err;
        int         ridx;
        exp_err = addr_err(addr);
        ridx    = int'(addr[7:0]);
        apb_xfer(wr, addr, data, rd, err);
        check($sformatf("pslverr of %s at 0x%03h", wr ? "write" : "read", addr),
              32'(err), 32'(exp_err));
        if (!wr && !exp_err)
            check($sformatf("prdata at 0x%03h", addr), 32'(rd), 32'(model_rdata(addr)));
        if (wr && !exp_err && ridx >= `PC_NUM_ID_REGS)
            scratch_mdl[int'(addr[11:8])][ridx - `PC_NUM_ID_REGS] = data; // ID writes dropped
    endtask

    task automatic sweep_scratch();
        for (int s = 0; s < `PC_NUM_SLOTS; s++)
            for (int r = 0; r < `PC_NUM_SCRATCH; r++)
                access(1'b0, make_addr(s, r + `PC_NUM_ID_REGS), 8'h00);
    endtask

    // Keeps the 1 ns drive phase, zero cycles is no gap
    task automatic idle(input int n);
        if (n > 0) begin
            repeat (n) @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    initial begin
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        cycles  = 0;
        void'($urandom(44));
        for (int s = 0; s < `PC_NUM_SLOTS; s++)
            for (int r = 0; r < `PC_NUM_SCRATCH; r++)
                scratch_mdl[s][r] = 8'h00;       // Reset value
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
        idle(1);

        sweep_scratch();                         // All zero after reset

        // ID bytes and writes to them that must not stick
        for (int s = 0; s < `PC_NUM_SLOTS; s++) begin
            access(1'b0, make_addr(s, 0), 8'h00);
            access(1'b0, make_addr(s, 1), 8'h00);
            access(1'b1, make_addr(s, 0), 8'($urandom));
            access(1'b1, make_addr(s, 1), 8'($urandom));
            access(1'b0, make_addr(s, 0), 8'h00);
            access(1'b0, make_addr(s, 1), 8'h00);
        end

        repeat (N_RAND_W) access(1'b1, random_scratch_addr(), 8'($urandom));
        repeat (N_RAND_R) access(1'b0, random_scratch_addr(), 8'h00);
        sweep_scratch();                         // No cross-slot disturbance

        repeat (N_BAD) access(1'($urandom % 2), unmapped_addr(), 8'($urandom));
        sweep_scratch();

        // Mixed traffic with short idle gaps
        repeat (N_MIX) begin
            access(1'($urandom % 2), any_addr(), 8'($urandom));
            idle(int'($urandom % 3));
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// File: pccore_top.f
+incdir+hdl
hdl/pc_bus_pkg.sv
hdl/pc_map_pkg.sv
hdl/apb_bus_bridge.sv
hdl/periph_slot.sv
hdl/bus_return.sv
hdl/pccore_top.sv
sim/pccore_checker.sv
sim/pccore_tb.sv

// File: Makefile
# Verilator build of the peripheral controller core testbench

TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = pccore_tb
FLIST   = pccore_top.f
OBJ_DIR = obj_dir
SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell sed -n 's/^\([^+].*\)$$/\1/p' $(FLIST)) hdl/pccore_consts.svh
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status of the simulation is the result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
